//--- hdl/mc_pkg.sv
// Memory controller package with bus widths, region map, response codes and channel structs
package mc_pkg;

    localparam int ID_W          = 4;
    localparam int ADDR_W        = 32;
    localparam int DATA_W        = 32;
    localparam int MAX_BURST_LEN = 16;
    localparam int OFFSET_W      = 13;
    localparam int ATT_ENTRY_W   = 31;

    // Region windows in byte addresses
    localparam logic [ADDR_W-1:0] ATT_BASE    = 32'h0000_0000;
    localparam logic [ADDR_W-1:0] ATT_SIZE    = 32'h0000_4000;
    localparam logic [ADDR_W-1:0] CLAUSE_BASE = 32'h0000_4000;
    localparam logic [ADDR_W-1:0] CLAUSE_SIZE = 32'h0001_E000;
    localparam logic [ADDR_W-1:0] VARCL1_BASE = 32'h0002_2000;
    localparam logic [ADDR_W-1:0] VARCL1_SIZE = 32'h0000_2000;
    localparam logic [ADDR_W-1:0] VARCL2_BASE = 32'h0002_4000;
    localparam logic [ADDR_W-1:0] VARCL2_SIZE = 32'h0000_2000;

    // AXI burst type encoding, only INCR is served
    localparam logic [1:0] BURST_INCR = 2'b01;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } resp_e;

    typedef enum logic [2:0] {
        REG_ATT    = 3'd0,
        REG_CLAUSE = 3'd1,
        REG_VARCL1 = 3'd2,
        REG_VARCL2 = 3'd3,
        REG_NONE   = 3'd4
    } region_e;

    // Shared by AW and AR
    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [ADDR_W-1:0] addr;
        logic [7:0]        len;
        logic [2:0]        size;
        logic [1:0]        burst;
    } axi_addr_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic              last;
    } axi_w_t;

    typedef struct packed {
        logic [ID_W-1:0] id;
        resp_e           resp;
    } axi_b_t;

    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [DATA_W-1:0] data;
        resp_e             resp;
        logic              last;
    } axi_r_t;

    typedef struct packed {
        region_e             region;
        logic                we;
        logic [OFFSET_W-1:0] offset;
        logic [DATA_W-1:0]   wdata;
    } table_req_t;

    // Only INCR bursts up to MAX_BURST_LEN beats pass
    function automatic logic burst_ok(logic [1:0] burst, logic [7:0] len);
        return (burst == BURST_INCR) && (len < MAX_BURST_LEN);
    endfunction

    // Keeps only the bits a region actually stores
    function automatic logic [DATA_W-1:0] shape_data(region_e region, logic [DATA_W-1:0] data);
        logic [DATA_W-1:0] shaped;
        shaped = '0;
        case (region)
            REG_ATT:                shaped[ATT_ENTRY_W-1:0] = data[ATT_ENTRY_W-1:0];
            REG_CLAUSE:             shaped = data;
            REG_VARCL1, REG_VARCL2: shaped[0] = data[0];
            default:                shaped = '0;
        endcase
        return shaped;
    endfunction

endpackage

//--- hdl/region_decoder.sv
// Region decoder mapping a byte address to a table region and its local offset
module region_decoder (
    input  logic [mc_pkg::ADDR_W-1:0]   addr_i,
    output mc_pkg::region_e             region_o,
    output logic [mc_pkg::OFFSET_W-1:0] offset_o
);
    import mc_pkg::*;

    // Distance from each base, wraps high when below the base
    logic [ADDR_W-1:0] att_rel;
    logic [ADDR_W-1:0] clause_rel;
    logic [ADDR_W-1:0] varcl1_rel;
    logic [ADDR_W-1:0] varcl2_rel;

    assign att_rel    = addr_i - ATT_BASE;
    assign clause_rel = addr_i - CLAUSE_BASE;
    assign varcl1_rel = addr_i - VARCL1_BASE;
    assign varcl2_rel = addr_i - VARCL2_BASE;

    // First matching window wins
    always_comb begin
        region_o = REG_NONE;
        offset_o = '0;
        if (att_rel < ATT_SIZE) begin
            region_o = REG_ATT;
            offset_o = att_rel[OFFSET_W-1:0];
        end else if (clause_rel < CLAUSE_SIZE) begin
            region_o = REG_CLAUSE;
            offset_o = clause_rel[OFFSET_W-1:0];
        end else if (varcl1_rel < VARCL1_SIZE) begin
            region_o = REG_VARCL1;
            offset_o = varcl1_rel[OFFSET_W-1:0];
        end else if (varcl2_rel < VARCL2_SIZE) begin
            region_o = REG_VARCL2;
            offset_o = varcl2_rel[OFFSET_W-1:0];
        end
    end

endmodule

//--- hdl/axi_write_engine.sv
// AXI write engine handling AW, W and B with one table write per accepted beat
module axi_write_engine (
    input  logic               clk_i,
    input  logic               rst_i,
    input  mc_pkg::axi_addr_t  aw_i,
    input  logic               aw_valid_i,
    output logic               aw_ready_o,
    input  mc_pkg::axi_w_t     w_i,
    input  logic               w_valid_i,
    output logic               w_ready_o,
    output mc_pkg::axi_b_t     b_o,
    output logic               b_valid_o,
    input  logic               b_ready_i,
    output mc_pkg::table_req_t req_o,
    output logic               req_valid_o
);
    import mc_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ADDR,
        ST_DATA,
        ST_RESP
    } state_e;

    state_e state_q;
    state_e state_d;

    // Latched burst parameters
    logic [ID_W-1:0]   id_q;
    logic [ADDR_W-1:0] addr_q;
    logic [2:0]        size_q;

    logic [7:0] beat_q;
    logic       burst_ok_q;
    logic       err_q;

    logic                aw_xfer;
    logic                w_xfer;
    logic                b_xfer;
    logic [ADDR_W-1:0]   beat_addr;
    region_e             beat_region;
    logic [OFFSET_W-1:0] beat_offset;

    assign aw_ready_o = (state_q == ST_ADDR);
    assign w_ready_o  = (state_q == ST_DATA);
    assign b_valid_o  = (state_q == ST_RESP);

    assign aw_xfer = aw_valid_i && aw_ready_o;
    assign w_xfer  = w_valid_i && w_ready_o;
    assign b_xfer  = b_valid_o && b_ready_i;

    assign beat_addr = addr_q + (ADDR_W'(beat_q) << size_q);

    region_decoder u_decoder (
        .addr_i   (beat_addr),
        .region_o (beat_region),
        .offset_o (beat_offset)
    );

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: state_d = ST_ADDR;
            ST_ADDR: if (aw_xfer) state_d = ST_DATA;
            ST_DATA: if (w_xfer && w_i.last) state_d = ST_RESP;
            ST_RESP: if (b_xfer) state_d = ST_ADDR;
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            state_q    <= ST_IDLE;
            beat_q     <= '0;
            burst_ok_q <= 1'b0;
            err_q      <= 1'b0;
        end else begin
            state_q <= state_d;
            if (aw_xfer) begin
                beat_q     <= '0;
                burst_ok_q <= burst_ok(aw_i.burst, aw_i.len);
                err_q      <= !burst_ok(aw_i.burst, aw_i.len);
            end else if (w_xfer) begin
                beat_q <= beat_q + 8'd1;
                if (beat_region == REG_NONE) begin
                    err_q <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (aw_xfer) begin
            id_q   <= aw_i.id;
            addr_q <= aw_i.addr;
            size_q <= aw_i.size;
        end
    end

    // Failed bursts and out-of-range beats never reach a table
    assign req_valid_o = w_xfer && burst_ok_q && (beat_region != REG_NONE);

    always_comb begin
        req_o.region = beat_region;
        req_o.we     = 1'b1;
        req_o.offset = beat_offset;
        req_o.wdata  = shape_data(beat_region, w_i.data);
    end

    always_comb begin
        b_o.id   = id_q;
        b_o.resp = err_q ? SLVERR : OKAY;
    end

    a_b_stable: assert property (@(posedge clk_i) disable iff (rst_i)
        b_valid_o && !b_ready_i |=> b_valid_o && $stable(b_o));

endmodule

//--- hdl/axi_read_engine.sv
// AXI read engine serving AR and R one beat at a time through the table bus
module axi_read_engine (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  mc_pkg::axi_addr_t         ar_i,
    input  logic                      ar_valid_i,
    output logic                      ar_ready_o,
    output mc_pkg::axi_r_t            r_o,
    output logic                      r_valid_o,
    input  logic                      r_ready_i,
    output mc_pkg::table_req_t        req_o,
    output logic                      req_valid_o,
    input  logic                      grant_i,
    input  logic [mc_pkg::DATA_W-1:0] tbl_rdata_i
);
    import mc_pkg::*;

    // BUS is the cycle the request sits on the table bus, CAP the cycle the data returns
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_ADDR,
        ST_REQ,
        ST_BUS,
        ST_CAP,
        ST_PRESENT
    } state_e;

    state_e state_q;
    state_e state_d;

    logic [ID_W-1:0]   id_q;
    logic [ADDR_W-1:0] addr_q;
    logic [7:0]        len_q;
    logic [2:0]        size_q;

    logic [7:0] beat_q;
    logic       burst_ok_q;
    axi_r_t     r_q;

    logic                ar_xfer;
    logic                r_xfer;
    logic                skip;
    logic                last_beat;
    logic [ADDR_W-1:0]   beat_addr;
    region_e             beat_region;
    logic [OFFSET_W-1:0] beat_offset;

    assign ar_ready_o = (state_q == ST_ADDR);
    assign r_valid_o  = (state_q == ST_PRESENT);

    assign ar_xfer = ar_valid_i && ar_ready_o;
    assign r_xfer  = r_valid_o && r_ready_i;

    assign beat_addr = addr_q + (ADDR_W'(beat_q) << size_q);
    assign last_beat = (beat_q == len_q);

    region_decoder u_decoder (
        .addr_i   (beat_addr),
        .region_o (beat_region),
        .offset_o (beat_offset)
    );

    // Beats with no valid table target are answered locally
    assign skip = !burst_ok_q || (beat_region == REG_NONE);

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: state_d = ST_ADDR;
            ST_ADDR: if (ar_xfer) state_d = ST_REQ;
            ST_REQ: begin
                if (skip) begin
                    state_d = ST_PRESENT;
                end else if (grant_i) begin
                    state_d = ST_BUS;
                end
            end
            ST_BUS:  state_d = ST_CAP;
            ST_CAP:  state_d = ST_PRESENT;
            ST_PRESENT: begin
                if (r_xfer) begin
                    state_d = last_beat ? ST_ADDR : ST_REQ;
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            state_q    <= ST_IDLE;
            beat_q     <= '0;
            burst_ok_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (ar_xfer) begin
                beat_q     <= '0;
                burst_ok_q <= burst_ok(ar_i.burst, ar_i.len);
            end else if (r_xfer && !last_beat) begin
                beat_q <= beat_q + 8'd1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (ar_xfer) begin
            id_q   <= ar_i.id;
            addr_q <= ar_i.addr;
            len_q  <= ar_i.len;
            size_q <= ar_i.size;
        end
    end

    // Registered R beat, held until the master takes it
    always_ff @(posedge clk_i) begin
        if (state_q == ST_REQ && skip) begin
            r_q.id   <= id_q;
            r_q.data <= '0;
            r_q.resp <= SLVERR;
            r_q.last <= last_beat;
        end else if (state_q == ST_CAP) begin
            r_q.id   <= id_q;
            r_q.data <= shape_data(beat_region, tbl_rdata_i);
            r_q.resp <= OKAY;
            r_q.last <= last_beat;
        end
    end

    assign r_o = r_q;

    assign req_valid_o = (state_q == ST_REQ) && !skip;

    always_comb begin
        req_o.region = beat_region;
        req_o.we     = 1'b0;
        req_o.offset = beat_offset;
        req_o.wdata  = '0;
    end

    a_r_stable: assert property (@(posedge clk_i) disable iff (rst_i)
        r_valid_o && !r_ready_i |=> r_valid_o && $stable(r_o));

endmodule

//--- hdl/table_port_arbiter.sv
// Table bus arbiter registering write or read requests, with writes served first
module table_port_arbiter (
    input  logic               clk_i,
    input  logic               rst_i,
    input  mc_pkg::table_req_t wr_req_i,
    input  logic               wr_valid_i,
    input  mc_pkg::table_req_t rd_req_i,
    input  logic               rd_valid_i,
    output logic               rd_grant_o,
    output mc_pkg::table_req_t tbl_req_o,
    output logic               tbl_req_valid_o
);
    import mc_pkg::*;

    // Write requests cannot stall, so the read waits out any write
    assign rd_grant_o = rd_valid_i && !wr_valid_i;

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            tbl_req_valid_o <= 1'b0;
        end else begin
            tbl_req_valid_o <= wr_valid_i || rd_grant_o;
        end
    end

    always_ff @(posedge clk_i) begin
        if (wr_valid_i) begin
            tbl_req_o <= wr_req_i;
        end else if (rd_grant_o) begin
            tbl_req_o <= rd_req_i;
        end
    end

    // A read that meets a write stays pending while the write takes the bus
    a_write_first: assert property (@(posedge clk_i) disable iff (rst_i)
        rd_valid_i && wr_valid_i |=> rd_valid_i && tbl_req_valid_o && tbl_req_o.we);

endmodule

//--- hdl/mem_controller_top.sv
// AXI4 slave memory controller top joining the write and read engines to the table bus
module mem_controller_top (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  mc_pkg::axi_addr_t         aw_i,
    input  logic                      aw_valid_i,
    output logic                      aw_ready_o,
    input  mc_pkg::axi_w_t            w_i,
    input  logic                      w_valid_i,
    output logic                      w_ready_o,
    output mc_pkg::axi_b_t            b_o,
    output logic                      b_valid_o,
    input  logic                      b_ready_i,
    input  mc_pkg::axi_addr_t         ar_i,
    input  logic                      ar_valid_i,
    output logic                      ar_ready_o,
    output mc_pkg::axi_r_t            r_o,
    output logic                      r_valid_o,
    input  logic                      r_ready_i,
    output mc_pkg::table_req_t        tbl_req_o,
    output logic                      tbl_req_valid_o,
    input  logic [mc_pkg::DATA_W-1:0] tbl_rdata_i
);
    import mc_pkg::*;

    table_req_t wr_req;
    logic       wr_req_valid;
    table_req_t rd_req;
    logic       rd_req_valid;
    logic       rd_grant;

    axi_write_engine u_write_engine (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .aw_i        (aw_i),
        .aw_valid_i  (aw_valid_i),
        .aw_ready_o  (aw_ready_o),
        .w_i         (w_i),
        .w_valid_i   (w_valid_i),
        .w_ready_o   (w_ready_o),
        .b_o         (b_o),
        .b_valid_o   (b_valid_o),
        .b_ready_i   (b_ready_i),
        .req_o       (wr_req),
        .req_valid_o (wr_req_valid)
    );

    axi_read_engine u_read_engine (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .ar_i        (ar_i),
        .ar_valid_i  (ar_valid_i),
        .ar_ready_o  (ar_ready_o),
        .r_o         (r_o),
        .r_valid_o   (r_valid_o),
        .r_ready_i   (r_ready_i),
        .req_o       (rd_req),
        .req_valid_o (rd_req_valid),
        .grant_i     (rd_grant),
        .tbl_rdata_i (tbl_rdata_i)
    );

    table_port_arbiter u_arbiter (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .wr_req_i        (wr_req),
        .wr_valid_i      (wr_req_valid),
        .rd_req_i        (rd_req),
        .rd_valid_i      (rd_req_valid),
        .rd_grant_o      (rd_grant),
        .tbl_req_o       (tbl_req_o),
        .tbl_req_valid_o (tbl_req_valid_o)
    );

endmodule

//--- testbench/tb_clock_gen.sv
// Testbench clock and reset source, 10 unit period with a 10 cycle reset
module tb_clock_gen (
    output logic clk_o,
    output logic rst_o
);
    localparam int HALF_PERIOD  = 5;
    localparam int RESET_CYCLES = 10;

    initial begin
        clk_o = 1'b0;
        forever #HALF_PERIOD clk_o = ~clk_o;
    end

    // Released on a falling edge, away from the stimulus slots
    initial begin
        rst_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_o = 1'b0;
    end

endmodule

//--- testbench/tb_table_models.sv
// Behavioral models of the ATT, clause and variable cluster tables behind the table bus
module tb_table_models (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  mc_pkg::table_req_t        tbl_req_i,
    input  logic                      tbl_req_valid_i,
    output logic [mc_pkg::DATA_W-1:0] tbl_rdata_o
);
    import mc_pkg::*;

    localparam int DEPTH = 2 ** OFFSET_W;

    logic [DATA_W-1:0] att_mem    [DEPTH];
    logic [DATA_W-1:0] clause_mem [DEPTH];
    logic [DATA_W-1:0] varcl1_mem [DEPTH];
    logic [DATA_W-1:0] varcl2_mem [DEPTH];

    // Background contents built from the full offset
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            att_mem[i]    = 32'hA000_0000 | i;
            clause_mem[i] = 32'hC000_0000 | i;
            varcl1_mem[i] = 32'h1000_0000 | i;
            varcl2_mem[i] = 32'h2000_0000 | i;
        end
    end

    always @(posedge clk_i) begin
        if (tbl_req_valid_i && tbl_req_i.we) begin
            case (tbl_req_i.region)
                REG_ATT:    att_mem[tbl_req_i.offset]    <= tbl_req_i.wdata;
                REG_CLAUSE: clause_mem[tbl_req_i.offset] <= tbl_req_i.wdata;
                REG_VARCL1: varcl1_mem[tbl_req_i.offset] <= tbl_req_i.wdata;
                REG_VARCL2: varcl2_mem[tbl_req_i.offset] <= tbl_req_i.wdata;
                default: ;
            endcase
        end
    end

    // Answers one cycle after a read, masked to the width each table keeps
    always @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            tbl_rdata_o <= '0;
        end else if (tbl_req_valid_i && !tbl_req_i.we) begin
            case (tbl_req_i.region)
                REG_ATT:    tbl_rdata_o <= att_mem[tbl_req_i.offset] & 32'h7FFF_FFFF;
                REG_CLAUSE: tbl_rdata_o <= clause_mem[tbl_req_i.offset];
                REG_VARCL1: tbl_rdata_o <= varcl1_mem[tbl_req_i.offset] & 32'h0000_0001;
                REG_VARCL2: tbl_rdata_o <= varcl2_mem[tbl_req_i.offset] & 32'h0000_0001;
                default:    tbl_rdata_o <= '0;
            endcase
        end
    end

endmodule

//--- testbench/tb_mem_controller.sv
// Directed testbench for the AXI4 slave memory controller and its table bus
module tb_mem_controller;
    import mc_pkg::*;

    localparam int TIMEOUT = 200;
    localparam logic [DATA_W-1:0] ATT_MASK    = 32'h7FFF_FFFF;
    localparam logic [DATA_W-1:0] CLAUSE_MASK = 32'hFFFF_FFFF;
    localparam logic [DATA_W-1:0] VAR_MASK    = 32'h0000_0001;
    localparam logic [1:0]        BURST_FIXED = 2'b00;
    localparam logic [1:0]        BURST_WRAP  = 2'b10;
    localparam logic [ID_W-1:0]   WR_ID       = 4'h5;
    localparam logic [ID_W-1:0]   RD_ID       = 4'hA;

    logic              clk;
    logic              rst;
    axi_addr_t         aw;
    logic              aw_valid;
    logic              aw_ready;
    axi_w_t            w;
    logic              w_valid;
    logic              w_ready;
    axi_b_t            b;
    logic              b_valid;
    logic              b_ready;
    axi_addr_t         ar;
    logic              ar_valid;
    logic              ar_ready;
    axi_r_t            r;
    logic              r_valid;
    logic              r_ready;
    table_req_t        tbl_req;
    logic              tbl_req_valid;
    logic [DATA_W-1:0] tbl_rdata;

    integer seed;
    int     error_count;
    int     timeout_count;

    // Beat buffers shared by the burst tasks and the tests
    logic [DATA_W-1:0] wr_data  [32];
    logic [DATA_W-1:0] exp_data [32];
    logic [DATA_W-1:0] rd_data  [32];
    resp_e             rd_resp  [32];
    logic              rd_last  [32];
    logic [ID_W-1:0]   rd_id    [32];
    logic [ID_W-1:0]   b_id;

    tb_clock_gen u_clock (
        .clk_o (clk),
        .rst_o (rst)
    );

    mem_controller_top DUT (
        .clk_i           (clk),
        .rst_i           (rst),
        .aw_i            (aw),
        .aw_valid_i      (aw_valid),
        .aw_ready_o      (aw_ready),
        .w_i             (w),
        .w_valid_i       (w_valid),
        .w_ready_o       (w_ready),
        .b_o             (b),
        .b_valid_o       (b_valid),
        .b_ready_i       (b_ready),
        .ar_i            (ar),
        .ar_valid_i      (ar_valid),
        .ar_ready_o      (ar_ready),
        .r_o             (r),
        .r_valid_o       (r_valid),
        .r_ready_i       (r_ready),
        .tbl_req_o       (tbl_req),
        .tbl_req_valid_o (tbl_req_valid),
        .tbl_rdata_i     (tbl_rdata)
    );

    tb_table_models u_tables (
        .clk_i           (clk),
        .rst_i           (rst),
        .tbl_req_i       (tbl_req),
        .tbl_req_valid_i (tbl_req_valid),
        .tbl_rdata_o     (tbl_rdata)
    );

    // Inputs change just after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout: %s did not arrive within %0d cycles", what, TIMEOUT);
        timeout_count++;
    endtask

    task automatic compare_resp(input string test, input resp_e exp, input resp_e act);
        if (act !== exp) begin
            $display("FAILED %s: expected resp %b actual resp %b", test, exp, act);
            error_count++;
        end
    endtask

    task automatic compare_data(input string test, input logic [DATA_W-1:0] exp,
                                input logic [DATA_W-1:0] act);
        if (act !== exp) begin
            $display("FAILED %s: expected data 0x%08h actual data 0x%08h", test, exp, act);
            error_count++;
        end
    endtask

    task automatic compare_last(input string test, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAILED %s: expected rlast %b actual rlast %b", test, exp, act);
            error_count++;
        end
    endtask

    task automatic compare_id(input string test, input logic [ID_W-1:0] exp,
                              input logic [ID_W-1:0] act);
        if (act !== exp) begin
            $display("FAILED %s: expected id 0x%0h actual id 0x%0h", test, exp, act);
            error_count++;
        end
    endtask

    // Bits each table region keeps
    function automatic logic [DATA_W-1:0] region_mask(input region_e region);
        case (region)
            REG_ATT:                return ATT_MASK;
            REG_CLAUSE:             return CLAUSE_MASK;
            REG_VARCL1, REG_VARCL2: return VAR_MASK;
            default:                return '0;
        endcase
    endfunction

    // Every table write carries only the bits its region keeps
    always @(negedge clk) begin
        if (!rst && tbl_req_valid && tbl_req.we) begin
            compare_data("table write width", '0,
                         tbl_req.wdata & ~region_mask(tbl_req.region));
        end
    end

    // Full write burst from wr_data, returns the B response
    task automatic write_burst(input logic [ADDR_W-1:0] addr, input logic [7:0] len,
                               input logic [1:0] burst, output resp_e resp);
        int cnt;
        int i;
        resp = SLVERR;
        b_id = '0;
        aw = '{id: WR_ID, addr: addr, len: len, size: 3'd2, burst: burst};
        aw_valid = 1'b1;
        cnt = 0;
        while (!aw_ready && cnt < TIMEOUT) begin
            next_cycle();
            cnt++;
        end
        if (!aw_ready) begin
            report_timeout("AW ready");
            aw_valid = 1'b0;
            return;
        end
        next_cycle();
        aw_valid = 1'b0;
        for (i = 0; i <= int'(len); i++) begin
            w.data = wr_data[i];
            w.last = (i == int'(len));
            w_valid = 1'b1;
            cnt = 0;
            while (!w_ready && cnt < TIMEOUT) begin
                next_cycle();
                cnt++;
            end
            if (!w_ready) begin
                report_timeout("W ready");
                w_valid = 1'b0;
                return;
            end
            next_cycle();
        end
        w_valid = 1'b0;
        cnt = 0;
        while (!b_valid && cnt < TIMEOUT) begin
            next_cycle();
            cnt++;
        end
        if (!b_valid) begin
            report_timeout("B valid");
            return;
        end
        resp = b.resp;
        b_id = b.id;
        b_ready = 1'b1;
        next_cycle();
        b_ready = 1'b0;
    endtask

    // B response and ID of the last write burst
    task automatic check_write(input string test, input resp_e exp_resp, input resp_e act_resp);
        compare_resp(test, exp_resp, act_resp);
        compare_id(test, WR_ID, b_id);
    endtask

    // Full read burst into rd_data, rd_resp, rd_last and rd_id
    task automatic read_burst(input logic [ADDR_W-1:0] addr, input logic [7:0] len,
                              input logic [1:0] burst, input bit backpressure);
        int          cnt;
        int          i;
        bit          taken;
        logic [31:0] rnd;
        ar = '{id: RD_ID, addr: addr, len: len, size: 3'd2, burst: burst};
        ar_valid = 1'b1;
        cnt = 0;
        while (!ar_ready && cnt < TIMEOUT) begin
            next_cycle();
            cnt++;
        end
        if (!ar_ready) begin
            report_timeout("AR ready");
            ar_valid = 1'b0;
            return;
        end
        next_cycle();
        ar_valid = 1'b0;
        for (i = 0; i <= int'(len); i++) begin
            taken = 1'b0;
            cnt = 0;
            while (!taken && cnt < TIMEOUT) begin
                rnd = $random(seed);
                r_ready = backpressure ? rnd[0] : 1'b1;
                if (r_valid && r_ready) begin
                    rd_data[i] = r.data;
                    rd_resp[i] = r.resp;
                    rd_last[i] = r.last;
                    rd_id[i]   = r.id;
                    taken = 1'b1;
                end
                next_cycle();
                cnt++;
            end
            if (!taken) begin
                report_timeout("R valid");
                r_ready = 1'b0;
                return;
            end
        end
        r_ready = 1'b0;
    endtask

    task automatic check_read(input string test, input int last_idx, input resp_e exp_resp);
        string name;
        for (int i = 0; i <= last_idx; i++) begin
            name = $sformatf("%s beat %0d", test, i);
            compare_data(name, exp_data[i], rd_data[i]);
            compare_resp(name, exp_resp, rd_resp[i]);
            compare_last(name, i == last_idx, rd_last[i]);
            compare_id(name, RD_ID, rd_id[i]);
        end
    endtask

    task automatic test_single_regions();
        logic [ADDR_W-1:0] addrs [4];
        logic [DATA_W-1:0] masks [4];
        string             names [4];
        resp_e             resp;
        addrs = '{32'h0000_0100, 32'h0000_5000, 32'h0002_2010, 32'h0002_4020};
        masks = '{ATT_MASK, CLAUSE_MASK, VAR_MASK, VAR_MASK};
        names = '{"single ATT", "single clause", "single varcl1", "single varcl2"};
        for (int k = 0; k < 4; k++) begin
            // Top bit set so the ATT mask is visible
            wr_data[0] = $random(seed) | 32'h8000_0000;
            write_burst(addrs[k], 8'd0, BURST_INCR, resp);
            check_write(names[k], OKAY, resp);
            exp_data[0] = wr_data[0] & masks[k];
            read_burst(addrs[k], 8'd0, BURST_INCR, 1'b0);
            check_read(names[k], 0, OKAY);
        end
    endtask

    task automatic test_clause_burst();
        resp_e resp;
        for (int i = 0; i < 16; i++) begin
            wr_data[i] = $random(seed);
            exp_data[i] = wr_data[i];
        end
        write_burst(32'h0000_6000, 8'd15, BURST_INCR, resp);
        check_write("clause burst write", OKAY, resp);
        read_burst(32'h0000_6000, 8'd15, BURST_INCR, 1'b1);
        check_read("clause burst read", 15, OKAY);
    endtask

    task automatic test_out_of_range();
        resp_e resp;
        wr_data[0] = $random(seed);
        wr_data[1] = $random(seed);
        // Second beat lands on the first address past VARCL2
        write_burst(32'h0002_5FFC, 8'd1, BURST_INCR, resp);
        check_write("range write", SLVERR, resp);
        exp_data[0] = wr_data[0] & VAR_MASK;
        read_burst(32'h0002_5FFC, 8'd0, BURST_INCR, 1'b0);
        check_read("range read inside", 0, OKAY);
        exp_data[0] = '0;
        read_burst(32'h0002_6000, 8'd0, BURST_INCR, 1'b0);
        check_read("range read outside", 0, SLVERR);
    endtask

    task automatic test_bad_bursts();
        resp_e resp;
        wr_data[0] = $random(seed);
        wr_data[1] = $random(seed);
        write_burst(32'h0000_0200, 8'd1, BURST_INCR, resp);
        check_write("bad burst setup", OKAY, resp);
        exp_data[0] = wr_data[0] & ATT_MASK;
        exp_data[1] = wr_data[1] & ATT_MASK;
        for (int i = 0; i < 17; i++) begin
            wr_data[i] = $random(seed);
        end
        write_burst(32'h0000_0200, 8'd0, BURST_FIXED, resp);
        check_write("fixed write", SLVERR, resp);
        write_burst(32'h0000_0200, 8'd16, BURST_INCR, resp);
        check_write("17 beat write", SLVERR, resp);
        read_burst(32'h0000_0200, 8'd1, BURST_INCR, 1'b0);
        check_read("bad burst readback", 1, OKAY);
        for (int i = 0; i < 4; i++) begin
            exp_data[i] = '0;
        end
        read_burst(32'h0000_0200, 8'd3, BURST_WRAP, 1'b0);
        check_read("wrap read", 3, SLVERR);
    endtask

    task automatic test_concurrent();
        resp_e             resp;
        logic [DATA_W-1:0] att_exp [4];
        for (int i = 0; i < 4; i++) begin
            wr_data[i] = $random(seed);
            exp_data[i] = wr_data[i] & VAR_MASK;
        end
        write_burst(32'h0002_2100, 8'd3, BURST_INCR, resp);
        check_write("concurrent setup", OKAY, resp);
        for (int i = 0; i < 4; i++) begin
            wr_data[i] = $random(seed);
            att_exp[i] = wr_data[i] & ATT_MASK;
        end
        // Writes hold the table bus while the read waits for a grant
        fork
            write_burst(32'h0000_0300, 8'd3, BURST_INCR, resp);
            read_burst(32'h0002_2100, 8'd3, BURST_INCR, 1'b1);
        join
        check_write("concurrent ATT write", OKAY, resp);
        check_read("concurrent varcl1 read", 3, OKAY);
        for (int i = 0; i < 4; i++) begin
            exp_data[i] = att_exp[i];
        end
        read_burst(32'h0000_0300, 8'd3, BURST_INCR, 1'b0);
        check_read("concurrent ATT readback", 3, OKAY);
    endtask

    initial begin
        int cnt;
        seed = 32'hbcc2_0b74;
        error_count = 0;
        timeout_count = 0;
        aw = '0;
        aw_valid = 1'b0;
        w = '0;
        w_valid = 1'b0;
        b_ready = 1'b0;
        ar = '0;
        ar_valid = 1'b0;
        r_ready = 1'b0;
        cnt = 0;
        next_cycle();
        while (rst && cnt < TIMEOUT) begin
            next_cycle();
            cnt++;
        end
        if (rst) begin
            report_timeout("Reset release");
        end else begin
            test_single_regions();
            test_clause_burst();
            test_out_of_range();
            test_bad_bursts();
            test_concurrent();
        end
        $display("Summary: %0d value errors, %0d timeouts", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- all.f
hdl/mc_pkg.sv
hdl/region_decoder.sv
hdl/axi_write_engine.sv
hdl/axi_read_engine.sv
hdl/table_port_arbiter.sv
hdl/mem_controller_top.sv
testbench/tb_clock_gen.sv
testbench/tb_table_models.sv
testbench/tb_mem_controller.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the memory controller testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_mem_controller -f all.f
if [ $? -ne 0 ]; then
    echo "Verilator compilation failed"
    exit 1
fi

./obj_dir/Vtb_mem_controller > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "Checks failed" "$LOG"; then
    echo "Failure found in $LOG"
    exit 1
fi

exit 0
